//--- project.f
src/riscv_isa_pkg.sv
src/datapath_pkg.sv
src/instruction_decoder.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv_alu_core.sv
testbench/rv_alu_core_properties.sv
testbench/rv_alu_core_tb.sv

//--- src/datapath_pkg.sv
////////////////////////////////////////////////////////////
// Datapath types shared by the decode and execute stages
////////////////////////////////////////////////////////////

package datapath_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Control and indices for one decoded instruction
    typedef struct packed {
        logic        valid;         // Slot holds an instruction
        logic        illegal;       // Unsupported opcode
        logic        write_enable;  // Low for rd == 0 and illegal
        logic        use_immediate; // Operand B from immediate
        alu_op_e     alu_op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] immediate;     // Already sign-extended
    } decoded_t;

    // Result on its way to the register file
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } writeback_t;

endpackage

//--- src/decode_stage.sv
////////////////////////////////////////////////////////////
// Forwards from execute and writeback, so no stalls needed
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage #(
    parameter int XLEN           = 32,
    parameter int REGISTER_COUNT = 32
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        instruction_valid,
    input  riscv_isa_pkg::instruction_t instruction,
    input  datapath_pkg::writeback_t    alu_result,
    input  datapath_pkg::writeback_t    writeback,
    output datapath_pkg::decoded_t      decoded,
    output logic [XLEN-1:0]             operand_a,
    output logic [XLEN-1:0]             operand_b
);

    logic [XLEN-1:0] file_data_a;
    logic [XLEN-1:0] file_data_b;
    logic [XLEN-1:0] source_b;

    // Newest producer wins; a valid result never carries rd 0
    function automatic logic [XLEN-1:0] forward(
        input logic [4:0]               index,
        input logic [XLEN-1:0]          file_data,
        input datapath_pkg::writeback_t newest,
        input datapath_pkg::writeback_t older
    );
        logic [XLEN-1:0] value;
        if (newest.valid && (newest.rd == index)) begin
            value = newest.data;
        end else if (older.valid && (older.rd == index)) begin
            value = older.data;
        end else begin
            value = file_data;
        end
        return value;
    endfunction

    instruction_decoder instruction_decoder_i (
        .instruction       (instruction),
        .instruction_valid (instruction_valid),
        .decoded           (decoded),
        .illegal           ()  // Already carried in decoded.illegal
    );

    register_file #(
        .XLEN           (XLEN),
        .REGISTER_COUNT (REGISTER_COUNT)
    ) register_file_i (
        .clock        (clock),
        .reset        (reset),
        .read_index_a (decoded.rs1),
        .read_index_b (decoded.rs2),
        .read_data_a  (file_data_a),
        .read_data_b  (file_data_b),
        .write        (writeback)
    );

    always_comb begin
        operand_a = forward(decoded.rs1, file_data_a, alu_result, writeback);
        source_b  = forward(decoded.rs2, file_data_b, alu_result, writeback);
        operand_b = decoded.use_immediate ? decoded.immediate : source_b;
    end

endmodule

//--- src/execute_stage.sv
////////////////////////////////////////////////////////////
// One ALU cycle, results and illegal leave registered
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage #(
    parameter int XLEN = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  datapath_pkg::decoded_t   decoded,
    input  logic [XLEN-1:0]          operand_a,
    input  logic [XLEN-1:0]          operand_b,
    output datapath_pkg::writeback_t alu_result,
    output datapath_pkg::writeback_t writeback,
    output logic                     illegal
);

    datapath_pkg::decoded_t ex_decoded;
    logic [XLEN-1:0]        ex_a;
    logic [XLEN-1:0]        ex_b;
    logic [XLEN-1:0]        alu_value;
    logic [4:0]             shift_amount;

    // Pipeline register between decode and execute
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ex_decoded <= '0;
        end else begin
            ex_decoded <= decoded;
        end
    end

    always_ff @(posedge clock) begin
        ex_a <= operand_a;
        ex_b <= operand_b;
    end

    assign shift_amount = ex_b[4:0];

    always_comb begin
        case (ex_decoded.alu_op)
            datapath_pkg::ALU_ADD:  alu_value = ex_a + ex_b;
            datapath_pkg::ALU_SUB:  alu_value = ex_a - ex_b;
            datapath_pkg::ALU_SLL:  alu_value = ex_a << shift_amount;
            datapath_pkg::ALU_SLT:  alu_value = XLEN'($signed(ex_a) < $signed(ex_b));
            datapath_pkg::ALU_SLTU: alu_value = XLEN'(ex_a < ex_b);
            datapath_pkg::ALU_XOR:  alu_value = ex_a ^ ex_b;
            datapath_pkg::ALU_SRL:  alu_value = ex_a >> shift_amount;
            datapath_pkg::ALU_SRA:  alu_value = XLEN'($signed(ex_a) >>> shift_amount);
            datapath_pkg::ALU_OR:   alu_value = ex_a | ex_b;
            datapath_pkg::ALU_AND:  alu_value = ex_a & ex_b;
            default:                alu_value = '0;
        endcase
    end

    // Visible to decode in the same cycle for distance-1 forwarding
    always_comb begin
        alu_result.valid = ex_decoded.valid && ex_decoded.write_enable;
        alu_result.rd    = ex_decoded.rd;
        alu_result.data  = alu_value;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            writeback <= '0;
            illegal   <= 1'b0;
        end else begin
            writeback <= alu_result;
            illegal   <= ex_decoded.valid && ex_decoded.illegal; // Single-cycle pulse
        end
    end

endmodule

//--- src/instruction_decoder.sv
////////////////////////////////////////////////////////////
// Pure combinational decode, OP and OP-IMM only
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instruction_decoder (
    input  riscv_isa_pkg::instruction_t instruction,
    input  logic                        instruction_valid,
    output datapath_pkg::decoded_t      decoded,
    output logic                        illegal
);

    // funct3 to ALU operation, the alternate bit picks SUB or SRA
    function automatic datapath_pkg::alu_op_e select_alu_op(
        input logic [2:0] funct3,
        input logic       alternate
    );
        datapath_pkg::alu_op_e op;
        case (funct3)
            riscv_isa_pkg::FUNCT3_ADD_SUB: begin
                if (alternate) op = datapath_pkg::ALU_SUB;
                else           op = datapath_pkg::ALU_ADD;
            end
            riscv_isa_pkg::FUNCT3_SLL:  op = datapath_pkg::ALU_SLL;
            riscv_isa_pkg::FUNCT3_SLT:  op = datapath_pkg::ALU_SLT;
            riscv_isa_pkg::FUNCT3_SLTU: op = datapath_pkg::ALU_SLTU;
            riscv_isa_pkg::FUNCT3_XOR:  op = datapath_pkg::ALU_XOR;
            riscv_isa_pkg::FUNCT3_SRL_SRA: begin
                if (alternate) op = datapath_pkg::ALU_SRA;
                else           op = datapath_pkg::ALU_SRL;
            end
            riscv_isa_pkg::FUNCT3_OR:   op = datapath_pkg::ALU_OR;
            default:                    op = datapath_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        decoded               = '0;
        decoded.valid         = instruction_valid;
        decoded.alu_op        = datapath_pkg::ALU_ADD;
        decoded.rd            = instruction.r.rd;
        decoded.rs1           = instruction.r.rs1;
        decoded.rs2           = instruction.r.rs2;
        decoded.immediate     = {{20{instruction.i.imm12[11]}}, instruction.i.imm12};

        case (instruction.r.opcode)
            riscv_isa_pkg::OP: begin
                decoded.alu_op = select_alu_op(instruction.r.funct3,
                        instruction.r.funct7 == riscv_isa_pkg::FUNCT7_ALT);
                decoded.write_enable = instruction_valid && (instruction.r.rd != 5'd0);
            end
            riscv_isa_pkg::OP_IMM: begin
                decoded.use_immediate = 1'b1;
                decoded.rs2           = 5'd0; // No second source, keeps forwarding quiet
                // There is no SUBI, so the alternate bit only matters for SRAI
                decoded.alu_op = select_alu_op(instruction.i.funct3,
                        (instruction.i.funct3 == riscv_isa_pkg::FUNCT3_SRL_SRA) &&
                        (instruction.i.imm12[11:5] == riscv_isa_pkg::FUNCT7_ALT));
                decoded.write_enable = instruction_valid && (instruction.i.rd != 5'd0);
            end
            default: begin
                decoded.illegal = instruction_valid;
            end
        endcase
    end

    assign illegal = decoded.illegal;

endmodule

//--- src/register_file.sv
////////////////////////////////////////////////////////////
// Asynchronous reads, x0 always zero, no internal bypass
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module register_file #(
    parameter int XLEN           = 32,
    parameter int REGISTER_COUNT = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [4:0]               read_index_a,
    input  logic [4:0]               read_index_b,
    output logic [XLEN-1:0]          read_data_a,
    output logic [XLEN-1:0]          read_data_b,
    input  datapath_pkg::writeback_t write
);

    logic [XLEN-1:0] registers [REGISTER_COUNT];

    // x0 is masked on the read side
    assign read_data_a = (read_index_a != 5'd0) ? registers[read_index_a] : '0;
    assign read_data_b = (read_index_b != 5'd0) ? registers[read_index_b] : '0;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < REGISTER_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write.valid && (write.rd != 5'd0)) begin
            registers[write.rd] <= write.data;
        end
    end

endmodule

//--- src/riscv_isa_pkg.sv
////////////////////////////////////////////////////////////
// RV32I base encodings for the OP and OP-IMM groups only
////////////////////////////////////////////////////////////

package riscv_isa_pkg;

    // Major opcodes handled by the slice, anything else is illegal
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    // funct3 field
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // SUB and SRA/SRAI

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // Register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word, viewed by format
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instruction_t;

endpackage

//--- src/rv_alu_core.sv
////////////////////////////////////////////////////////////
// Two-cycle latency, one instruction per cycle, no stall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_alu_core #(
    parameter int XLEN           = 32, // Only 32 matches the package widths
    parameter int REGISTER_COUNT = 32
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        instruction_valid,
    input  riscv_isa_pkg::instruction_t instruction,
    output datapath_pkg::writeback_t    writeback,
    output logic                        illegal
);

    datapath_pkg::decoded_t   decoded;
    datapath_pkg::writeback_t alu_result;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;

    decode_stage #(
        .XLEN           (XLEN),
        .REGISTER_COUNT (REGISTER_COUNT)
    ) decode_stage_i (
        .clock             (clock),
        .reset             (reset),
        .instruction_valid (instruction_valid),
        .instruction       (instruction),
        .alu_result        (alu_result),
        .writeback         (writeback),   // Also the register file write port
        .decoded           (decoded),
        .operand_a         (operand_a),
        .operand_b         (operand_b)
    );

    execute_stage #(
        .XLEN (XLEN)
    ) execute_stage_i (
        .clock      (clock),
        .reset      (reset),
        .decoded    (decoded),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_result (alu_result),
        .writeback  (writeback),
        .illegal    (illegal)
    );

endmodule

//--- testbench/rv_alu_core_properties.sv
////////////////////////////////////////////////////////////
// Bound into rv_alu_core and relies on its two-cycle latency
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_alu_core_properties (
    input logic                     clock,
    input logic                     reset,
    input logic                     instruction_valid,
    input datapath_pkg::writeback_t writeback,
    input logic                     illegal
);

    int failure_count = 0; // Failed assertions so far, read at the end of the run

    // A slot leaves either as a result or as an illegal pulse
    one_result_per_cycle: assert property (
        @(posedge clock) disable iff (!reset) !(writeback.valid && illegal)
    ) else begin
        failure_count++;
        $error("writeback.valid and illegal are high in the same cycle");
    end

    no_write_to_x0: assert property (
        @(posedge clock) disable iff (!reset) writeback.valid |-> (writeback.rd != 5'd0)
    ) else begin
        failure_count++;
        $error("writeback.valid is high with rd equal to 0");
    end

    quiet_after_reset: assert property (
        @(posedge clock) $rose(reset) |-> (!writeback.valid && !illegal)
    ) else begin
        failure_count++;
        $error("outputs are not low in the first cycle after reset");
    end

    // Every output traces back to a strobe two edges earlier
    output_from_strobe: assert property (
        @(posedge clock) disable iff (!reset)
            (writeback.valid || illegal) |-> $past(instruction_valid, 2)
    ) else begin
        failure_count++;
        $error("output without an instruction strobe two cycles earlier");
    end

endmodule

bind rv_alu_core rv_alu_core_properties rv_alu_core_properties_i (
    .clock             (clock),
    .reset             (reset),
    .instruction_valid (instruction_valid),
    .writeback         (writeback),
    .illegal           (illegal)
);

//--- testbench/rv_alu_core_stim.txt
# gap instruction kind rd data   (gap = idle cycles before issue, rd decimal, data hex)
# kind W expects a writeback, N no output at all, I an illegal pulse
0 ffb00093 W 1  fffffffb  # addi x1, x0, -5
0 00300113 W 2  00000003  # addi x2, x0, 3
0 002081b3 W 3  fffffffe  # add  x3, x1, x2
0 40208233 W 4  fffffff8  # sub  x4, x1, x2
0 002092b3 W 5  ffffffd8  # sll  x5, x1, x2
0 0020a333 W 6  00000001  # slt  x6, x1, x2
0 0020b3b3 W 7  00000000  # sltu x7, x1, x2
0 0020c433 W 8  fffffff8  # xor  x8, x1, x2
0 0020d4b3 W 9  1fffffff  # srl  x9, x1, x2
0 4020d533 W 10 ffffffff  # sra  x10, x1, x2
0 0020e5b3 W 11 fffffffb  # or   x11, x1, x2
0 0020f633 W 12 00000003  # and  x12, x1, x2
1 00409693 W 13 ffffffb0  # slli x13, x1, 4
0 ffc0a713 W 14 00000001  # slti x14, x1, -4
0 ffc0b793 W 15 00000001  # sltiu x15, x1, -4
0 fff0c813 W 16 00000004  # xori x16, x1, -1
0 0040d893 W 17 0fffffff  # srli x17, x1, 4
0 4040d913 W 18 ffffffff  # srai x18, x1, 4
0 07016993 W 19 00000073  # ori  x19, x2, 0x70
0 0f00fa13 W 20 000000f0  # andi x20, x1, 0xf0
2 00700a93 W 21 00000007  # addi x21, x0, 7
0 001a8a93 W 21 00000008  # addi x21, x21, 1 at distance 1
0 06400b13 W 22 00000064  # addi x22, x0, 100
0 016a8bb3 W 23 0000006c  # add  x23, x21, x22 at distances 2 and 1
0 017a8c33 W 24 00000074  # add  x24, x21, x23 at distances 3 and 1
0 00100c93 W 25 00000001  # addi x25, x0, 1
0 002c8c93 W 25 00000003  # addi x25, x25, 2
0 019c8d33 W 26 00000006  # add  x26, x25, x25 newest of two writers
3 00208033 N 0  00000000  # add  x0, x1, x2
0 00508013 N 0  00000000  # addi x0, x1, 5
0 00200db3 W 27 00000003  # add  x27, x0, x2
1 12345137 I 0  00000000  # lui  x2 is unsupported
0 00002083 I 0  00000000  # lw   x1 is unsupported
0 00208e33 W 28 fffffffe  # add  x28, x1, x2 sees no change
4 00000000 I 0  00000000  # all-zero word
0 40110eb3 W 29 00000008  # sub  x29, x2, x1

//--- testbench/rv_alu_core_tb.sv
////////////////////////////////////////////////////////////
// Run from the project root since the stimulus path is relative
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_alu_core_tb;

    localparam int    XLEN          = 32;
    localparam int    DRAIN_LIMIT   = 50;
    localparam string STIMULUS_FILE = "testbench/rv_alu_core_stim.txt";

    // One expected outcome tagged with its due cycle
    typedef struct packed {
        int unsigned              due;
        logic [7:0]               kind;   // W, N or I
        datapath_pkg::writeback_t result;
    } expectation_t;

    logic                        clock = 1'b0;
    logic                        reset;
    logic                        instruction_valid;
    riscv_isa_pkg::instruction_t instruction;
    datapath_pkg::writeback_t    writeback;
    logic                        illegal;

    int unsigned  cycle = 0;
    expectation_t expected_queue[$];

    rv_alu_core #(
        .XLEN           (XLEN),
        .REGISTER_COUNT (32)
    ) rv_alu_core_i (
        .clock             (clock),
        .reset             (reset),
        .instruction_valid (instruction_valid),
        .instruction       (instruction),
        .writeback         (writeback),
        .illegal           (illegal)
    );

    always #4 clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string message);
        abort_run($sformatf("** Error at %0d ns: %s", $time, message));
    endtask

    task automatic check_writeback(
        input datapath_pkg::writeback_t actual,
        input datapath_pkg::writeback_t expected,
        input string                    label
    );
        if (actual.valid !== expected.valid) begin
            report_mismatch($sformatf("%s writeback.valid is %b, expected %b",
                    label, actual.valid, expected.valid));
        end else if (expected.valid &&
                ((actual.rd !== expected.rd) || (actual.data !== expected.data))) begin
            report_mismatch($sformatf("%s writeback x%0d = %h, expected x%0d = %h",
                    label, actual.rd, actual.data, expected.rd, expected.data));
        end
    endtask

    task automatic check_illegal(input logic actual, input logic expected, input string label);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s illegal is %b, expected %b", label, actual, expected));
        end
    endtask

    task automatic drive_idle();
        @(posedge clock);
        #1;
        instruction_valid = 1'b0;
        instruction       = '0;
    endtask

    task automatic issue_instruction(
        input logic [31:0] word,
        input logic [7:0]  kind,
        input logic [4:0]  rd,
        input logic [31:0] data
    );
        expectation_t entry;
        @(posedge clock);
        #1;
        instruction_valid  = 1'b1;
        instruction        = word;
        entry.due          = cycle + 2; // Two edges from strobe to output
        entry.kind         = kind;
        entry.result.valid = (kind == "W");
        entry.result.rd    = (kind == "W") ? rd : 5'd0;
        entry.result.data  = (kind == "W") ? data : '0;
        expected_queue.push_back(entry);
    endtask

    // Outputs are sampled mid-cycle clear of both edges
    always @(negedge clock) begin
        expectation_t             head;
        datapath_pkg::writeback_t idle_result;
        if (reset) begin
            idle_result = '0;
            if ((expected_queue.size() != 0) && (expected_queue[0].due == cycle)) begin
                head = expected_queue.pop_front();
                check_writeback(writeback, head.result, $sformatf("cycle %0d", cycle));
                check_illegal(illegal, head.kind == "I", $sformatf("cycle %0d", cycle));
            end else begin
                check_writeback(writeback, idle_result, $sformatf("idle cycle %0d", cycle));
                check_illegal(illegal, 1'b0, $sformatf("idle cycle %0d", cycle));
            end
        end
    end

    always @(rv_alu_core_i.rv_alu_core_properties_i.failure_count) begin
        if (rv_alu_core_i.rv_alu_core_properties_i.failure_count != 0) begin
            abort_run("A bound assertion failed during the run");
        end
    end

    initial begin
        int          fd;
        int          fields;
        int          gap;
        int          rd_value;
        int unsigned wait_cycles;
        logic [31:0] word;
        logic [31:0] data;
        logic [7:0]  kind;
        string       line;

        reset             = 1'b0;
        instruction_valid = 1'b0;
        instruction       = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b1;

        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            abort_run({"Could not open the stimulus file ", STIMULUS_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            if ((line.len() <= 1) || (line.getc(0) == "#")) begin
                continue; // Blank or column notes
            end
            fields = $sscanf(line, "%d %h %c %d %h", gap, word, kind, rd_value, data);
            if ((fields != 5) || !(kind inside {"W", "N", "I"})) begin
                abort_run({"Malformed stimulus line: ", line});
            end
            repeat (gap) drive_idle();
            issue_instruction(word, kind, rd_value[4:0], data);
        end
        $fclose(fd);
        drive_idle();

        wait_cycles = 0;
        while (expected_queue.size() != 0) begin
            @(posedge clock);
            wait_cycles++;
            if (wait_cycles > DRAIN_LIMIT) begin
                abort_run("Timeout while waiting for the last expected results");
            end
        end
        repeat (4) @(posedge clock); // Quiet tail while the monitor keeps checking

        if (rv_alu_core_i.rv_alu_core_properties_i.failure_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("One or more bound assertions failed during the run");
        end
    end

endmodule
